// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall
TOP        = bk_top_tb
RTL_TOP    = bk_top
FILELIST   = bk_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bk_top.f
+incdir+hw
hw/bk_types_pkg.sv
hw/sd_pkg.sv
hw/bk_status.sv
hw/bk_sequencer.sv
hw/bk_format_timer.sv
hw/bk_ram.sv
hw/bk_top.sv
test/bk_top_asserts.sv
test/bk_top_tb.sv

// File: hw/bk_cfg.svh
/*
 Backup RAM configuration macros
 Sector count, address widths and format header words
*/
`ifndef BK_CFG_SVH
`define BK_CFG_SVH

// Save image layout
`define BK_SECTORS   4      // 512-byte sectors per save
`define BK_RAM_AW    11     // Console byte address, 2 KiB
`define BK_WORD_AW   10     // Host side word address
`define BK_BUF_AW    8      // Word address inside one sector

// Format header
`define BK_FMT_WORDS 4
`define BK_FMT_W0    16'h5548   // "HU"
`define BK_FMT_W1    16'h4D42   // "BM"
`define BK_FMT_W2    16'h8800
`define BK_FMT_W3    16'h8010

`endif

// File: hw/bk_format_timer.sv
/*
 Format sequence, writes the header words to the start of the RAM
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_format_timer (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        format,
	output logic                        fill_active,
	output bk_types_pkg::bk_word_addr_t fill_addr,
	output sd_pkg::sd_word_t            fill_data
);

	import bk_types_pkg::*;
	import sd_pkg::*;

	logic old_format;
	logic [$clog2(`BK_FMT_WORDS)-1:0] fill_idx;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_format  <= 1'b0;
			fill_active <= 1'b0;
			fill_idx    <= '0;
		end else begin
			old_format <= format;
			if (format & ~old_format) begin
				fill_active <= 1'b1;  // First word goes out next cycle
				fill_idx    <= '0;
			end else if (fill_active) begin
				if (fill_idx == ($bits(fill_idx))'(`BK_FMT_WORDS - 1))
					fill_active <= 1'b0;
				else
					fill_idx <= fill_idx + 1'b1;
			end
		end
	end

	assign fill_addr = bk_word_addr_t'(fill_idx);

	always_comb begin
		case (fill_idx)
			2'd0:    fill_data = `BK_FMT_W0;
			2'd1:    fill_data = `BK_FMT_W1;
			2'd2:    fill_data = `BK_FMT_W2;
			default: fill_data = `BK_FMT_W3;
		endcase
	end

endmodule

// File: hw/bk_ram.sv
/*
 Backup RAM, byte port for the console, word port for host and format
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_ram (
	input  logic                        clk_sys,
	// Console side
	input  bk_types_pkg::bk_ram_addr_t  bram_addr,
	input  bk_types_pkg::bk_byte_t      bram_data,
	input  logic                        bram_wr,
	output bk_types_pkg::bk_byte_t      bram_q,
	// Host side
	input  bk_types_pkg::bk_sector_t    sector,
	input  sd_pkg::sd_buf_addr_t        sd_buff_addr,
	input  sd_pkg::sd_word_t            sd_buff_dout,
	input  logic                        sd_buff_wr,
	input  logic                        sd_ack,
	output sd_pkg::sd_word_t            sd_buff_din,
	// Format side
	input  logic                        fill_active,
	input  bk_types_pkg::bk_word_addr_t fill_addr,
	input  sd_pkg::sd_word_t            fill_data
);

	import bk_types_pkg::*;
	import sd_pkg::*;

	// Index 0 is the even byte, low half of the host word
	logic [1:0][7:0] mem [0:(2**`BK_WORD_AW)-1];

	bk_word_addr_t byte_word;
	logic          byte_sel;
	bk_word_addr_t word_addr;
	sd_word_t      word_data;
	logic          word_we;

	assign byte_word = bram_addr[`BK_RAM_AW-1:1];
	assign byte_sel  = bram_addr[0];

	//////////////////////////////////////////////////
	// Word port mux, format fill takes priority
	//////////////////////////////////////////////////

	assign word_addr = fill_active ? fill_addr : {sector, sd_buff_addr};
	assign word_data = fill_active ? fill_data : sd_buff_dout;
	assign word_we   = fill_active | (sd_buff_wr & sd_ack);

	always_ff @(posedge clk_sys) begin
		if (bram_wr)
			mem[byte_word][byte_sel] <= bram_data;
		if (word_we)
			mem[word_addr] <= word_data;

		bram_q      <= mem[byte_word][byte_sel];  // One cycle after address
		sd_buff_din <= mem[word_addr];
	end

endmodule

// File: hw/bk_sequencer.sv
/*
 Sector walk FSM for load and save
 Drives the host request lines and the sector number
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_sequencer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     start_load,
	input  logic                     start_save,
	input  logic                     sd_ack,
	output sd_pkg::sd_lba_t          sd_lba,
	output bk_types_pkg::bk_sector_t sector,
	output logic                     sd_rd,
	output logic                     sd_wr,
	output logic                     busy,
	output logic                     bk_loading
);

	import bk_types_pkg::*;
	import sd_pkg::*;

	bk_state_t state;
	logic old_ack;
	logic ack_rise;
	logic ack_fall;
	logic last_sector;

	assign ack_rise    = sd_ack & ~old_ack;
	assign ack_fall    = ~sd_ack & old_ack;
	assign last_sector = (sector == bk_sector_t'(`BK_SECTORS - 1));

	assign busy   = (state != BK_IDLE);
	assign sd_lba = sd_lba_t'(sector);  // Save image starts at sector 0

	//////////////////////////////////////////////////
	// Request / transfer FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			old_ack    <= 1'b0;
			sector     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_ack <= sd_ack;

			case (state)
				BK_IDLE: begin
					// Load wins if both edges land together
					if (start_load | start_save) begin
						state      <= BK_REQUEST;
						bk_loading <= start_load;
						sector     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end

				BK_REQUEST: begin
					if (ack_rise) begin
						sd_rd <= 1'b0;  // Host has taken the request
						sd_wr <= 1'b0;
						state <= BK_TRANSFER;
					end
				end

				BK_TRANSFER: begin
					// Host may hold ack as long as it likes
					if (ack_fall) begin
						if (last_sector) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
							sector     <= '0;
						end else begin
							state  <= BK_REQUEST;
							sector <= sector + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end

				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

// File: hw/bk_status.sv
/*
 Save enable, pending flag and start request edges
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_status (
	input  logic clk_sys,
	input  logic reset,
	input  logic download,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic osd_status,
	input  logic autosave,
	input  logic bk_load,
	input  logic bk_save,
	input  logic bram_wr,
	input  logic busy,
	output logic start_load,
	output logic start_save,
	output logic bk_pending
);

	logic bk_ena;
	logic old_download;
	logic old_load;
	logic old_save;
	logic save_req;
	logic download_end;

	// Manual save, or autosave once the OSD opens with changes
	assign save_req     = bk_save | (bk_pending & osd_status & autosave);
	assign download_end = old_download & ~download;

	// One-cycle pulses, sequencer drops them when not idle
	assign start_load = bk_ena & ((bk_load & ~old_load) | download_end);
	assign start_save = bk_ena & save_req & ~old_save;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= download;
			old_load     <= bk_load;
			old_save     <= save_req;

			if (download & ~old_download)
				bk_ena <= 1'b0;  // New cartridge, old save no longer valid
			// Save image is mounted while the download is still running
			if (download & img_mounted & ~img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena & ~osd_status & bram_wr)
				bk_pending <= 1'b1;
			else if (busy)
				bk_pending <= 1'b0;
		end
	end

endmodule

// File: hw/bk_top.sv
/*
 Backup RAM save/load controller top level
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_top (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       download,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       osd_status,
	input  logic                       autosave,
	input  logic                       bk_load,
	input  logic                       bk_save,
	input  logic                       format,
	input  bk_types_pkg::bk_ram_addr_t bram_addr,
	input  bk_types_pkg::bk_byte_t     bram_data,
	input  logic                       bram_wr,
	input  logic                       sd_ack,
	input  sd_pkg::sd_buf_addr_t       sd_buff_addr,
	input  sd_pkg::sd_word_t           sd_buff_dout,
	input  logic                       sd_buff_wr,
	output sd_pkg::sd_lba_t            sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output sd_pkg::sd_word_t           sd_buff_din,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_pending,
	output bk_types_pkg::bk_byte_t     bram_q
);

	import bk_types_pkg::*;
	import sd_pkg::*;

	logic          start_load;
	logic          start_save;
	bk_sector_t    sector;
	logic          fill_active;
	bk_word_addr_t fill_addr;
	sd_word_t      fill_data;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	bk_status u_status (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.download     (download),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_status   (osd_status),
		.autosave     (autosave),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.bram_wr      (bram_wr),
		.busy         (bk_busy),
		.start_load   (start_load),
		.start_save   (start_save),
		.bk_pending   (bk_pending)
	);

	bk_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.start_load (start_load),
		.start_save (start_save),
		.sd_ack     (sd_ack),
		.sd_lba     (sd_lba),
		.sector     (sector),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.busy       (bk_busy),
		.bk_loading (bk_loading)  // Used upstream as a system reset hold
	);

	bk_format_timer u_format (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.format      (format),
		.fill_active (fill_active),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data)
	);

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	bk_ram u_ram (
		.clk_sys      (clk_sys),
		.bram_addr    (bram_addr),
		.bram_data    (bram_data),
		.bram_wr      (bram_wr),
		.bram_q       (bram_q),
		.sector       (sector),
		.sd_buff_addr (sd_buff_addr),
		.sd_buff_dout (sd_buff_dout),
		.sd_buff_wr   (sd_buff_wr),
		.sd_ack       (sd_ack),
		.sd_buff_din  (sd_buff_din),
		.fill_active  (fill_active),
		.fill_addr    (fill_addr),
		.fill_data    (fill_data)
	);

endmodule

// File: hw/bk_types_pkg.sv
/*
 Backup RAM side types and sequencer state
*/
`include "bk_cfg.svh"

package bk_types_pkg;

	// Console port
	typedef logic [`BK_RAM_AW-1:0] bk_ram_addr_t;
	typedef logic [7:0] bk_byte_t;

	// Word port, sector index in the top bits
	typedef logic [`BK_WORD_AW-1:0] bk_word_addr_t;
	typedef logic [$clog2(`BK_SECTORS)-1:0] bk_sector_t;

	// Sector walk
	typedef enum logic [1:0] {
		BK_IDLE,
		BK_REQUEST,   // rd or wr raised, waiting for ack
		BK_TRANSFER   // ack high, host moving words
	} bk_state_t;

endpackage

// File: hw/sd_pkg.sv
/*
 Host sector-buffer port types
*/
`include "bk_cfg.svh"

package sd_pkg;

	typedef logic [31:0] sd_lba_t;                 // Sector number
	typedef logic [`BK_BUF_AW-1:0] sd_buf_addr_t;  // Word inside the buffer
	typedef logic [15:0] sd_word_t;                // Low byte first

endpackage

// File: test/bk_top_asserts.sv
/*
 Concurrent checks on the host request lines
*/
`timescale 1ns/1ps

module bk_top_asserts (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic bk_busy
);

	// One direction per request
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	// Host ack takes the request away on the next cycle
	req_drop_on_ack: assert property (@(posedge clk_sys) disable iff (reset)
		($rose(sd_ack) && (sd_rd || sd_wr)) |=> !(sd_rd || sd_wr))
		else $error("request still high one cycle after the sd_ack rise");

	// No request while the sequencer is idle
	req_only_busy: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> bk_busy)
		else $error("request line high while bk_busy is low");

endmodule

// File: test/bk_top_tb.sv
/*
 Directed testbench for the backup RAM controller
 Host sector model, console port access and compare tasks
*/
`timescale 1ns/1ps
`include "bk_cfg.svh"

module bk_top_tb;

	import bk_types_pkg::*;
	import sd_pkg::*;

	localparam int WORDS = 2**`BK_BUF_AW;
	localparam int BYTES = 2**`BK_RAM_AW;
	// Worst case per sector is 15 wait, 257 word cycles, 15 hold
	localparam int XFER_MAX    = `BK_SECTORS * (WORDS + 2 * 15 + 6);
	localparam int CYCLE_LIMIT = 4 * (2 * BYTES + 4 * XFER_MAX + 100);

	logic clk_sys, reset;
	logic download, img_mounted, img_readonly, osd_status, autosave;
	logic bk_load, bk_save, format;
	bk_ram_addr_t bram_addr;
	bk_byte_t bram_data, bram_q;
	logic bram_wr;
	logic sd_ack, sd_buff_wr;
	sd_buf_addr_t sd_buff_addr;
	sd_word_t sd_buff_dout, sd_buff_din;
	sd_lba_t sd_lba;
	logic sd_rd, sd_wr, bk_busy, bk_loading, bk_pending;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [15:0] lfsr;
	bk_byte_t exp_bytes [0:BYTES-1];  // Expected console bytes for read_check

	bk_top DUT (.*);

	bind bk_top bk_top_asserts u_asserts (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sd_rd   (sd_rd),
		.sd_wr   (sd_wr),
		.sd_ack  (sd_ack),
		.bk_busy (bk_busy)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: simulation stopped after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_wait();
		int n;
		int i;
		n = 0;
		for (i = 0; i < 4; i++)
			n = (n << 1) | int'(lfsr_bit());
		return n;
	endfunction

	function automatic bk_byte_t byte_pat(input bk_ram_addr_t a);
		return a[7:0] ^ a[`BK_RAM_AW-1:3] ^ 8'h5A;
	endfunction

	function automatic sd_word_t word_pat(input bk_word_addr_t w);
		return sd_word_t'(w) * 16'h9E37 ^ 16'h1234;  // Odd multiplier spreads every bit
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_byte(input string name, input bk_byte_t got, input bk_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input sd_word_t got, input sd_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_lba(input string name, input sd_lba_t got, input sd_lba_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Host sector model and console reads
	//////////////////////////////////////////////////

	task automatic serve_sector(input bit is_save, input bit move, input int s);
		int n;
		int w;
		while (!(sd_rd || sd_wr)) @(negedge clk_sys);
		check_lba("sd_lba", sd_lba, sd_lba_t'(s));
		check_flag("sd_wr", sd_wr, is_save);
		check_flag("sd_rd", sd_rd, !is_save);
		check_flag("bk_busy", bk_busy, 1'b1);
		check_flag("bk_loading", bk_loading, !is_save);
		repeat (rand_wait()) @(negedge clk_sys);
		sd_ack = 1'b1;
		@(negedge clk_sys);
		check_flag("sd_rd | sd_wr", sd_rd | sd_wr, 1'b0);
		if (move && is_save) begin
			// Each check sees the address set one cycle earlier
			for (n = 0; n <= WORDS; n++) begin
				w = s * WORDS + n - 1;
				if (n > 0)
					check_word("sd_buff_din", sd_buff_din,
						{byte_pat(bk_ram_addr_t'(2 * w + 1)), byte_pat(bk_ram_addr_t'(2 * w))});
				if (n < WORDS)
					sd_buff_addr = sd_buf_addr_t'(n);
				@(negedge clk_sys);
			end
		end else if (move) begin
			for (n = 0; n < WORDS; n++) begin
				sd_buff_addr = sd_buf_addr_t'(n);
				sd_buff_dout = word_pat(bk_word_addr_t'(s * WORDS + n));
				sd_buff_wr   = 1'b1;
				@(negedge clk_sys);
			end
			sd_buff_wr = 1'b0;
		end else begin
			repeat (rand_wait()) @(negedge clk_sys);  // Ack held with nothing moved
		end
		// Still busy right up to the ack fall
		check_flag("bk_busy", bk_busy, 1'b1);
		check_flag("bk_loading", bk_loading, !is_save);
		sd_ack = 1'b0;
	endtask

	task automatic run_transfer(input bit is_save, input bit move);
		int s;
		for (s = 0; s < `BK_SECTORS; s++)
			serve_sector(is_save, move, s);
		@(negedge clk_sys);
		check_flag("bk_busy", bk_busy, 1'b0);
		check_flag("bk_loading", bk_loading, 1'b0);
	endtask

	task automatic read_check(input int count);
		int a;
		for (a = 0; a <= count; a++) begin
			if (a > 0)
				check_byte("bram_q", bram_q, exp_bytes[a-1]);
			if (a < count)
				bram_addr = bk_ram_addr_t'(a);
			@(negedge clk_sys);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check_flag("sd_rd", sd_rd, 1'b0);
		check_flag("sd_wr", sd_wr, 1'b0);
		check_flag("bk_busy", bk_busy, 1'b0);
		check_flag("bk_loading", bk_loading, 1'b0);
		check_flag("bk_pending", bk_pending, 1'b0);
		bk_load = 1'b1;  // Saving still disabled
		@(negedge clk_sys);
		bk_load = 1'b0;
		@(negedge clk_sys);
		check_flag("bk_busy", bk_busy, 1'b0);
	endtask

	task automatic test_save();
		int a;
		download = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		for (a = 0; a < BYTES; a++) begin
			bram_addr = bk_ram_addr_t'(a);
			bram_data = byte_pat(bk_ram_addr_t'(a));
			bram_wr   = 1'b1;
			@(negedge clk_sys);
		end
		bram_wr = 1'b0;
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		run_transfer(1'b1, 1'b1);
	endtask

	task automatic test_load();
		int a;
		sd_word_t wd;
		bk_load = 1'b1;
		@(negedge clk_sys);
		bk_load = 1'b0;
		run_transfer(1'b0, 1'b1);
		for (a = 0; a < BYTES; a++) begin
			wd = word_pat(bk_word_addr_t'(a / 2));
			exp_bytes[a] = (a % 2 == 1) ? wd[15:8] : wd[7:0];
		end
		read_check(BYTES);
	endtask

	task automatic test_auto_load();
		download = 1'b0;  // End of download while enabled
		run_transfer(1'b0, 1'b0);
	endtask

	task automatic test_autosave();
		bram_addr = bk_ram_addr_t'(BYTES - 1);
		bram_data = 8'hA5;
		bram_wr   = 1'b1;
		@(negedge clk_sys);
		bram_wr = 1'b0;
		check_flag("bk_pending", bk_pending, 1'b1);
		autosave   = 1'b1;
		osd_status = 1'b1;
		run_transfer(1'b1, 1'b0);
		check_flag("bk_pending", bk_pending, 1'b0);
		osd_status = 1'b0;
		autosave   = 1'b0;
	endtask

	task automatic test_format();
		sd_word_t hdr [0:3];
		int k;
		hdr[0] = `BK_FMT_W0;
		hdr[1] = `BK_FMT_W1;
		hdr[2] = `BK_FMT_W2;
		hdr[3] = `BK_FMT_W3;
		format = 1'b1;
		@(negedge clk_sys);
		format = 1'b0;
		repeat (`BK_FMT_WORDS + 1) @(negedge clk_sys);  // Fill runs four cycles after the edge
		for (k = 0; k < `BK_FMT_WORDS; k++) begin
			exp_bytes[2 * k]     = hdr[k][7:0];
			exp_bytes[2 * k + 1] = hdr[k][15:8];
		end
		read_check(2 * `BK_FMT_WORDS);
	endtask

	initial begin
		lfsr = 16'd25584;
		reset = 1'b1;
		download = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		osd_status = 1'b0;
		autosave = 1'b0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		format = 1'b0;
		bram_addr = '0;
		bram_data = '0;
		bram_wr = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;

		test_reset_state();
		test_save();
		test_load();
		test_auto_load();
		test_autosave();
		test_format();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
